// File: conv_pkg.sv
package conv_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] coef_t;
	typedef logic signed [19:0] result_t;   // nine 17-bit products plus growth
	typedef logic [31:0] addr_t;
	typedef logic [6:0] dim_t;

	localparam int MAX_WIDTH = 64;
	localparam int MAX_HEIGHT = 64;
	localparam int MIN_DIM = 3;
	localparam int COL_BITS = $clog2(MAX_WIDTH);

	localparam int WIN_SIZE = 3;
	localparam int NUM_COEFS = WIN_SIZE * WIN_SIZE;

	// config stream order is start word, width, height, start address, coefs 0..8
	localparam addr_t START_CMD = 32'h0000_0001;
	localparam int CONFIG_WORDS = 12;

	localparam int MAC_LATENCY = 2;

endpackage

// File: conv_config_loader.sv
`timescale 1ns/1ps

module conv_config_loader
	import conv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  load_en,
	input  addr_t data_mem,
	input  logic  mapped_data_valid,
	output logic  start_seen,
	output logic  config_done,
	output dim_t  image_width,
	output dim_t  image_height,
	output addr_t start_address,
	output coef_t coefs [NUM_COEFS]
);

	logic       capturing;
	logic [3:0] word_idx;

	function automatic dim_t clamp_dim(addr_t word, int unsigned limit);
		if (word < MIN_DIM)
			return dim_t'(MIN_DIM);
		if (word > limit)
			return dim_t'(limit);
		return dim_t'(word);
	endfunction

	assign start_seen = load_en && !capturing && mapped_data_valid && (data_mem == START_CMD);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			capturing <= 1'b0;
			word_idx <= '0;
			config_done <= 1'b0;
		end else begin
			config_done <= 1'b0;
			if (start_seen) begin
				capturing <= 1'b1;
				word_idx <= '0;
			end else if (capturing && mapped_data_valid) begin
				word_idx <= word_idx + 1'b1;
				if (word_idx == 4'(CONFIG_WORDS - 1)) begin
					capturing <= 1'b0;
					config_done <= 1'b1;   // one cycle after last word
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capturing && mapped_data_valid) begin
			case (word_idx)
				4'd0: image_width <= clamp_dim(data_mem, MAX_WIDTH);
				4'd1: image_height <= clamp_dim(data_mem, MAX_HEIGHT);
				4'd2: start_address <= data_mem;
				default: coefs[word_idx - 4'd3] <= coef_t'(data_mem[7:0]);   // low byte only
			endcase
		end
	end

endmodule

// File: conv_controller.sv
`timescale 1ns/1ps

module conv_controller
	import conv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_seen,
	input  logic  config_done,
	input  dim_t  image_width,
	input  dim_t  image_height,
	input  addr_t start_address,
	input  logic  making_request,
	input  logic  pixel_valid,
	input  dim_t  col,
	input  dim_t  row,
	input  logic  col_last,
	input  logic  row_last,
	output logic  load_en,
	output logic  counter_clear,
	output logic  shift_cols,
	output logic  window_valid,
	output addr_t out_address,
	output logic  request_read,
	output addr_t read_address,
	output logic  done,
	output logic  busy
);

	typedef enum logic [2:0] {
		IDLE,
		LOAD_CONFIG,
		ROW_REQUEST,
		ROW_STREAM,
		DRAIN,
		DONE
	} state_e;

	state_e      state;
	state_e      next;
	logic [1:0]  drain_cnt;
	logic [13:0] row_offset;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= next;
	end

	always_comb begin
		next = state;
		case (state)
			IDLE: if (start_seen)
				next = LOAD_CONFIG;
			LOAD_CONFIG: if (config_done)
				next = ROW_REQUEST;
			ROW_REQUEST: if (!making_request)
				next = ROW_STREAM;
			ROW_STREAM: if (shift_cols && col_last)
				next = row_last ? DRAIN : ROW_REQUEST;
			DRAIN: if (drain_cnt == 2'(MAC_LATENCY - 1))
				next = DONE;
			DONE:
				next = IDLE;
			default:
				next = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			drain_cnt <= '0;
		else if (state == DRAIN)
			drain_cnt <= drain_cnt + 1'b1;
		else
			drain_cnt <= '0;
	end

	// result index counts interior windows row-major
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			out_address <= '0;
		else if (counter_clear)
			out_address <= '0;
		else if (window_valid)
			out_address <= out_address + 1'b1;
	end

	assign row_offset = row * image_width;

	assign load_en = (state == IDLE);
	assign busy = (state != IDLE);
	assign counter_clear = (state == LOAD_CONFIG);
	assign shift_cols = (state == ROW_STREAM) && pixel_valid;
	assign window_valid = shift_cols && (row >= WIN_SIZE - 1) && (col >= WIN_SIZE - 1);
	assign request_read = (state == ROW_REQUEST) && !making_request;
	assign read_address = start_address + addr_t'(row_offset);
	assign done = (state == DONE);

endmodule

// File: conv_counter.sv
`timescale 1ns/1ps

module conv_counter
	import conv_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic step,
	input  dim_t image_width,
	input  dim_t image_height,
	output dim_t col,
	output dim_t row,
	output logic col_last,
	output logic row_last
);

	assign col_last = (col == image_width - 1'b1);
	assign row_last = (row == image_height - 1'b1);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (clear) begin
			col <= '0;
			row <= '0;
		end else if (step) begin
			if (col_last) begin
				col <= '0;
				row <= row + 1'b1;   // ends at height after last pixel
			end else begin
				col <= col + 1'b1;
			end
		end
	end

endmodule

// File: conv_line_buffer.sv
`timescale 1ns/1ps

module conv_line_buffer
	import conv_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   shift_cols,
	input  dim_t   col,
	input  pixel_t pixel,
	output pixel_t tap_up1,
	output pixel_t tap_up2
);

	pixel_t row_up1 [MAX_WIDTH];
	pixel_t row_up2 [MAX_WIDTH];

	logic [MAX_WIDTH-1:0] filled_up1;   // column written at least once
	logic [MAX_WIDTH-1:0] filled_up2;
	logic [COL_BITS-1:0]  idx;

	assign idx = col[COL_BITS-1:0];

	// unwritten slots read as zero
	assign tap_up1 = filled_up1[idx] ? row_up1[idx] : '0;
	assign tap_up2 = filled_up2[idx] ? row_up2[idx] : '0;

	always_ff @(posedge clk) begin
		if (shift_cols) begin
			row_up1[idx] <= pixel;
			row_up2[idx] <= tap_up1;   // row above moves up one
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			filled_up1 <= '0;
			filled_up2 <= '0;
		end else if (shift_cols) begin
			filled_up1[idx] <= 1'b1;
			filled_up2[idx] <= filled_up1[idx];
		end
	end

endmodule

// File: conv_window_mac.sv
`timescale 1ns/1ps

module conv_window_mac
	import conv_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    shift_cols,
	input  logic    window_valid,
	input  pixel_t  pixel,
	input  pixel_t  tap_up1,
	input  pixel_t  tap_up2,
	input  coef_t   coefs [NUM_COEFS],
	input  addr_t   out_address,
	output result_t result,
	output logic    result_valid,
	output addr_t   write_address
);

	typedef logic signed [16:0] prod_t;

	pixel_t  hist [WIN_SIZE][WIN_SIZE-1];   // older columns with index 0 oldest
	pixel_t  live [WIN_SIZE];
	pixel_t  win [NUM_COEFS];
	prod_t   prod_q [NUM_COEFS];
	addr_t   addr_q;
	logic    valid_q;
	result_t sum;

	assign live[0] = tap_up2;
	assign live[1] = tap_up1;
	assign live[2] = pixel;

	// window including the incoming column
	always_comb begin
		for (int r = 0; r < WIN_SIZE; r++) begin
			for (int c = 0; c < WIN_SIZE - 1; c++)
				win[r*WIN_SIZE + c] = hist[r][c];
			win[r*WIN_SIZE + WIN_SIZE - 1] = live[r];
		end
	end

	always_ff @(posedge clk) begin
		if (shift_cols) begin
			for (int r = 0; r < WIN_SIZE; r++) begin
				for (int c = 0; c < WIN_SIZE - 2; c++)
					hist[r][c] <= hist[r][c+1];
				hist[r][WIN_SIZE-2] <= live[r];
			end
		end
	end

	// stage one registers the products
	always_ff @(posedge clk) begin
		if (window_valid) begin
			for (int k = 0; k < NUM_COEFS; k++)
				prod_q[k] <= $signed({1'b0, win[k]}) * coefs[k];
			addr_q <= out_address;
		end
	end

	always_comb begin
		sum = '0;
		for (int k = 0; k < NUM_COEFS; k++)
			sum += result_t'(prod_q[k]);
	end

	// stage two sums into the result
	always_ff @(posedge clk) begin
		if (valid_q) begin
			result <= sum;
			write_address <= addr_q;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			valid_q <= window_valid;
			result_valid <= valid_q;
		end
	end

endmodule

// File: conv_top.sv
`timescale 1ns/1ps

module conv_top
	import conv_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  addr_t   data_mem,
	input  logic    mapped_data_valid,
	input  logic    making_request,
	input  pixel_t  pixel,
	input  logic    pixel_valid,
	output logic    request_read,
	output addr_t   read_address,
	output result_t result,
	output logic    result_valid,
	output addr_t   write_address,
	output logic    done,
	output logic    busy
);

	logic   load_en;
	logic   start_seen;
	logic   config_done;
	dim_t   image_width;
	dim_t   image_height;
	addr_t  start_address;
	coef_t  coefs [NUM_COEFS];
	logic   counter_clear;
	logic   shift_cols;
	logic   window_valid;
	addr_t  out_address;
	dim_t   col;
	dim_t   row;
	logic   col_last;
	logic   row_last;
	pixel_t tap_up1;
	pixel_t tap_up2;

	conv_config_loader loader (
		.clk               (clk),
		.rst_n             (rst_n),
		.load_en           (load_en),
		.data_mem          (data_mem),
		.mapped_data_valid (mapped_data_valid),
		.start_seen        (start_seen),
		.config_done       (config_done),
		.image_width       (image_width),
		.image_height      (image_height),
		.start_address     (start_address),
		.coefs             (coefs)
	);

	conv_controller controller (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_seen     (start_seen),
		.config_done    (config_done),
		.image_width    (image_width),
		.image_height   (image_height),
		.start_address  (start_address),
		.making_request (making_request),
		.pixel_valid    (pixel_valid),
		.col            (col),
		.row            (row),
		.col_last       (col_last),
		.row_last       (row_last),
		.load_en        (load_en),
		.counter_clear  (counter_clear),
		.shift_cols     (shift_cols),
		.window_valid   (window_valid),
		.out_address    (out_address),
		.request_read   (request_read),
		.read_address   (read_address),
		.done           (done),
		.busy           (busy)
	);

	conv_counter counter (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (counter_clear),
		.step         (shift_cols),
		.image_width  (image_width),
		.image_height (image_height),
		.col          (col),
		.row          (row),
		.col_last     (col_last),
		.row_last     (row_last)
	);

	conv_line_buffer line_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.shift_cols (shift_cols),
		.col        (col),
		.pixel      (pixel),
		.tap_up1    (tap_up1),
		.tap_up2    (tap_up2)
	);

	conv_window_mac mac (
		.clk           (clk),
		.rst_n         (rst_n),
		.shift_cols    (shift_cols),
		.window_valid  (window_valid),
		.pixel         (pixel),
		.tap_up1       (tap_up1),
		.tap_up2       (tap_up2),
		.coefs         (coefs),
		.out_address   (out_address),
		.result        (result),
		.result_valid  (result_valid),
		.write_address (write_address)
	);

endmodule

// File: conv_properties.sv
`timescale 1ns/1ps

module conv_properties (
	input logic clk,
	input logic rst_n,
	input logic request_read,
	input logic making_request,
	input logic done,
	input logic shift_cols,
	input logic pixel_valid
);

	int fail_count = 0;

	no_request_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		request_read |-> !making_request)
		else begin
			fail_count++;
			$error("request_read while making_request is high");
		end

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else begin
			fail_count++;
			$error("done longer than one cycle");
		end

	shift_needs_pixel: assert property (@(posedge clk) disable iff (!rst_n)
		shift_cols |-> pixel_valid)
		else begin
			fail_count++;
			$error("shift_cols without pixel_valid");
		end

endmodule

bind conv_controller conv_properties props (
	.clk            (clk),
	.rst_n          (rst_n),
	.request_read   (request_read),
	.making_request (making_request),
	.done           (done),
	.shift_cols     (shift_cols),
	.pixel_valid    (pixel_valid)
);

// File: conv_tb.sv
`timescale 1ns/1ps

module conv_tb
	import conv_pkg::*;
();

	localparam int TOTAL_PIXELS = 6*5 + 8*6 + 7*5 + 3*3 + 10*4;

	logic    clk = 1'b0;
	logic    rst_n;
	addr_t   data_mem;
	logic    mapped_data_valid;
	logic    making_request;
	pixel_t  pixel;
	logic    pixel_valid;
	logic    request_read;
	addr_t   read_address;
	result_t result;
	logic    result_valid;
	addr_t   write_address;
	logic    done;
	logic    busy;

	pixel_t  img [MAX_HEIGHT][MAX_WIDTH];
	coef_t   coef_cfg [NUM_COEFS];
	result_t exp_res [$];
	addr_t   exp_addr [$];
	int      exp_cycle [$];   // sample cycle at which each result is due
	result_t got_res [$];
	addr_t   got_addr [$];

	integer seed = 32'hf167;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int done_count = 0;
	int done_cycle = -1;
	int last_res_cycle = -1;
	int last_pix_cycle = -1;
	int busy_span = 0;

	conv_top UUT (
		.clk               (clk),
		.rst_n             (rst_n),
		.data_mem          (data_mem),
		.mapped_data_valid (mapped_data_valid),
		.making_request    (making_request),
		.pixel             (pixel),
		.pixel_valid       (pixel_valid),
		.request_read      (request_read),
		.read_address      (read_address),
		.result            (result),
		.result_valid      (result_valid),
		.write_address     (write_address),
		.done              (done),
		.busy              (busy)
	);

	always #20 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic compare_result(input string name, input result_t got, input result_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_address(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// result monitor samples values just before each rising edge
	always @(posedge clk) begin
		if (rst_n && result_valid) begin
			got_res.push_back(result);
			got_addr.push_back(write_address);
			last_res_cycle = cycle;
			if (exp_cycle.size() == 0)
				report_failure($sformatf("result at cycle %0d with no window pending", cycle));
			else if (exp_cycle[0] != cycle)
				report_failure($sformatf("result at cycle %0d, expected at cycle %0d",
					cycle, exp_cycle[0]));
			if (exp_cycle.size() != 0)
				void'(exp_cycle.pop_front());
		end
		if (rst_n && done) begin
			done_count++;
			done_cycle = cycle;
		end
	end

	task automatic fill_pattern(input int w, input int h);
		for (int r = 0; r < h; r++)
			for (int c = 0; c < w; c++)
				img[r][c] = pixel_t'(r * 37 + c * 11 + r * c + 5);
	endtask

	task automatic fill_random(input int w, input int h);
		for (int r = 0; r < h; r++)
			for (int c = 0; c < w; c++)
				img[r][c] = pixel_t'($random(seed));
	endtask

	task automatic random_coefs();
		for (int k = 0; k < NUM_COEFS; k++) begin
			coef_cfg[k] = coef_t'($random(seed));
			if (k % 2 == 0)
				coef_cfg[k][7] = 1'b1;   // enough negative taps for negative sums
		end
	endtask

	// expected outputs from the window rule
	task automatic build_expected(input int w, input int h);
		int acc;
		exp_res.delete();
		exp_addr.delete();
		for (int r = 2; r < h; r++) begin
			for (int c = 2; c < w; c++) begin
				acc = 0;
				for (int i = 0; i < 3; i++)
					for (int j = 0; j < 3; j++)
						acc += int'(coef_cfg[i*3 + j]) * int'(img[r-2+i][c-2+j]);
				exp_res.push_back(result_t'(acc));
				exp_addr.push_back(addr_t'((r - 2) * (w - 2) + (c - 2)));
			end
		end
	endtask

	task automatic send_config(input int w, input int h, input addr_t base);
		addr_t words [CONFIG_WORDS + 1];
		words[0] = START_CMD;
		words[1] = addr_t'(w);
		words[2] = addr_t'(h);
		words[3] = base;
		for (int k = 0; k < NUM_COEFS; k++)
			words[4 + k] = {24'h5a5a5a, coef_cfg[k]};   // junk above the low byte
		for (int i = 0; i <= CONFIG_WORDS; i++) begin
			if (i == 6) begin
				@(negedge clk);
				mapped_data_valid = 1'b0;   // idle gap mid stream
			end
			@(negedge clk);
			mapped_data_valid = 1'b1;
			data_mem = words[i];
		end
		@(negedge clk);
		mapped_data_valid = 1'b0;
		data_mem = '0;
	endtask

	// memory model serves one row per request
	task automatic serve_rows(input int w, input int h, input addr_t base,
			input int gap_max, input int busy_max);
		int gap;
		for (int r = 0; r < h; r++) begin
			if (making_request) begin
				repeat (busy_span) begin
					@(posedge clk);
					compare_flag("request_read", request_read, 1'b0);   // held off while busy
					@(negedge clk);
				end
				making_request = 1'b0;
			end
			do @(posedge clk); while (!request_read);
			compare_address("read_address", read_address, base + addr_t'(r * w));
			for (int c = 0; c < w; c++) begin
				gap = (gap_max > 0) ? int'($unsigned($random(seed)) % (gap_max + 1)) : 0;
				repeat (gap) begin
					@(negedge clk);
					pixel_valid = 1'b0;
				end
				@(negedge clk);
				pixel_valid = 1'b1;
				pixel = img[r][c];
				if (r >= 2 && c >= 2)
					exp_cycle.push_back(cycle + MAC_LATENCY);
				if (r == h - 1 && c == w - 1)
					last_pix_cycle = cycle;
				if (c == w - 1 && r < h - 1 && busy_max > 0) begin
					making_request = 1'b1;
					busy_span = 1 + int'($unsigned($random(seed)) % busy_max);
				end
			end
			@(negedge clk);
			pixel_valid = 1'b0;
			pixel = '0;
		end
	endtask

	task automatic run_job(input int w, input int h, input addr_t base,
			input int gap_max, input int busy_max);
		int waited;
		build_expected(w, h);
		got_res.delete();
		got_addr.delete();
		exp_cycle.delete();
		done_count = 0;
		done_cycle = -1;
		last_res_cycle = -1;
		last_pix_cycle = -1;
		if (busy_max > 0) begin
			@(negedge clk);
			making_request = 1'b1;   // busy before the first row
			busy_span = busy_max;
		end
		send_config(w, h, base);
		serve_rows(w, h, base, gap_max, busy_max);
		waited = 0;
		while (done_count == 0 && waited < 4 * MAC_LATENCY + 8) begin
			@(negedge clk);
			waited++;
		end
		repeat (4) @(negedge clk);   // room for a stray second pulse
		if (done_count == 0)
			report_failure($sformatf("%0dx%0d job ended without a done pulse", w, h));
		else if (done_count > 1)
			report_failure($sformatf("%0dx%0d job gave %0d done pulses", w, h, done_count));
		else if (done_cycle <= last_res_cycle)
			report_failure($sformatf("%0dx%0d job signalled done before its last result", w, h));
		else if (done_cycle != last_pix_cycle + MAC_LATENCY + 1)
			report_failure($sformatf("%0dx%0d job signalled done at cycle %0d instead of %0d",
				w, h, done_cycle, last_pix_cycle + MAC_LATENCY + 1));
		if (got_res.size() != exp_res.size()) begin
			report_failure($sformatf("%0dx%0d job gave %0d results instead of %0d",
				w, h, got_res.size(), exp_res.size()));
		end else begin
			for (int k = 0; k < exp_res.size(); k++) begin
				compare_result("result", got_res[k], exp_res[k]);
				compare_address("write_address", got_addr[k], exp_addr[k]);
			end
		end
		compare_flag("busy", busy, 1'b0);
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s passed", name);
		end else begin
			failed_tests++;
			$display("test %s failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_idle();
		int e0;
		e0 = errors;
		for (int i = 0; i < 13; i++) begin
			@(negedge clk);
			mapped_data_valid = (i < 12) && (i % 3 != 2);
			data_mem = addr_t'(i) * 32'h0101_0100 + 32'h2;   // never the start word
			@(posedge clk);
			compare_flag("request_read", request_read, 1'b0);
			compare_flag("result_valid", result_valid, 1'b0);
			compare_flag("done", done, 1'b0);
			compare_flag("busy", busy, 1'b0);
		end
		@(negedge clk);
		data_mem = '0;
		end_test("reset_idle", e0);
	endtask

	task automatic test_identity();
		int e0;
		e0 = errors;
		fill_pattern(6, 5);
		for (int k = 0; k < NUM_COEFS; k++)
			coef_cfg[k] = (k == 4) ? 8'sd1 : 8'sd0;
		run_job(6, 5, 32'h0000_1000, 0, 0);
		end_test("identity", e0);
	endtask

	task automatic test_random_filter();
		int e0;
		e0 = errors;
		fill_random(8, 6);
		random_coefs();
		run_job(8, 6, 32'h0002_0000, 2, 0);
		end_test("random_filter", e0);
	endtask

	task automatic test_busy_memory();
		int e0;
		e0 = errors;
		fill_random(7, 5);
		random_coefs();
		run_job(7, 5, 32'h0010_0040, 1, 5);
		end_test("busy_memory", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		e0 = errors;
		fill_random(3, 3);
		random_coefs();
		run_job(3, 3, 32'h0000_0300, 0, 0);
		fill_pattern(10, 4);
		random_coefs();
		run_job(10, 4, 32'h0000_8000, 1, 2);
		end_test("back_to_back", e0);
	endtask

	initial begin
		repeat (TOTAL_PIXELS * 40 + 2000) @(posedge clk);
		$display("timeout: run did not finish within the cycle limit");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		data_mem = '0;
		mapped_data_valid = 1'b0;
		making_request = 1'b0;
		pixel = '0;
		pixel_valid = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_reset_idle();
		test_identity();
		test_random_filter();
		test_busy_memory();
		test_back_to_back();

		errors += UUT.controller.props.fail_count;   // assertion failures
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: sim.f
conv_pkg.sv
conv_config_loader.sv
conv_controller.sv
conv_counter.sv
conv_line_buffer.sv
conv_window_mac.sv
conv_top.sv
conv_properties.sv
conv_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and search the simulator output for the pass line
verilator --binary --timing --assert -f sim.f --top-module conv_tb -o conv_sim \
	&& ./obj_dir/conv_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
